//--- hw/icache_pkg.sv
// geometry is fixed at 16 sets of 128-bit lines; changing it needs matching edits in users
package icache_pkg;

  // line geometry
  localparam int unsigned line_width = 128;
  localparam int unsigned line_words = line_width / 32;

  // address split
  localparam int unsigned addr_width   = 32;
  localparam int unsigned index_width  = 4;
  localparam int unsigned offset_width = 4;

  // kind of word on the return path
  typedef enum logic {
    rtrn_fill_ack = 1'b0,
    rtrn_inv_req  = 1'b1
  } rtrn_type_e;

  // invalidation view of the return payload
  typedef struct packed {
    logic [line_width-index_width-2:0] pad;
    logic                              all;
    logic [index_width-1:0]            idx;
  } rtrn_inv_t;

  // one payload word, read as line data or as an invalidation
  typedef union packed {
    logic [line_width-1:0] data;
    rtrn_inv_t             inv;
  } rtrn_payload_u;

  // word carried by the return queue
  typedef struct packed {
    rtrn_type_e    rtype;
    rtrn_payload_u payload;
  } rtrn_t;

  // refill request carried by the request queue
  typedef struct packed {
    logic [addr_width-1:0] paddr;
    logic                  nc;
  } req_t;

endpackage

//--- hw/stream_fifo.sv
// first-word-fall-through queue; depth must be at least 2, contents are not reset
`timescale 1ns/10ps

module stream_fifo #(
  parameter int unsigned depth = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  dtype data_i,
  output logic valid_o,
  input  logic ready_i,
  output dtype data_o
);

  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  dtype             mem_q [depth];
  logic             push;
  logic             pop;

  assign ready_o = (count_q < cnt_w'(depth));
  assign valid_o = (count_q != '0);
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;
  // head entry is visible without a read cycle
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_w'(depth))
    else $error("fifo count above depth");

  a_head_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("fifo head changed while stalled");

endmodule

//--- hw/icache_core.sv
// blocking direct-mapped cache; one miss at a time, non-cacheable fetches are never allocated
`timescale 1ns/10ps

module icache_core #(
  parameter int unsigned cached_addr_beg = 2048
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_valid_i,
  input  logic [31:0]         fetch_addr_i,
  output logic                fetch_ready_o,
  output logic                fetch_rsp_valid_o,
  output logic [31:0]         fetch_rsp_data_o,
  output logic [31:0]         fetch_rsp_addr_o,
  input  logic                fetch_rsp_ready_i,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  output logic [31:0]         req_paddr_o,
  output logic                req_nc_o,
  input  logic                rtrn_valid_i,
  input  icache_pkg::rtrn_t   rtrn_i
);

  import icache_pkg::*;

  localparam int unsigned tag_width = addr_width - index_width - offset_width;
  localparam int unsigned sets      = 2 ** index_width;

  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_lookup    = 3'd1;
  localparam logic [2:0] st_miss_req  = 3'd2;
  localparam logic [2:0] st_miss_wait = 3'd3;
  localparam logic [2:0] st_respond   = 3'd4;

  logic [2:0]            state_q;
  logic [2:0]            state_d;
  logic [sets-1:0]       valid_q;
  logic                  stale_q;
  logic [31:0]           addr_q;
  logic [31:0]           rsp_data_q;
  logic [tag_width-1:0]  tag_q  [sets];
  logic [line_width-1:0] line_q [sets];

  logic [index_width-1:0] idx;
  logic [tag_width-1:0]   tag;
  logic [1:0]             word_sel;
  logic                   nc;
  logic                   inv_valid;
  logic [index_width-1:0] inv_idx;
  logic                   hit;
  logic [31:0]            hit_word;
  logic                   fill_valid;
  logic                   fill_alloc;
  logic [31:0]            fill_word;

  assign idx      = addr_q[offset_width +: index_width];
  assign tag      = addr_q[addr_width-1 -: tag_width];
  assign word_sel = addr_q[offset_width-1:2];
  assign nc       = (addr_q < cached_addr_beg);

  assign inv_valid = rtrn_valid_i && (rtrn_i.rtype == rtrn_inv_req);
  assign inv_idx   = rtrn_i.payload.inv.idx;

  // an invalidation arriving during lookup already counts as a miss
  assign hit      = !nc && valid_q[idx] && (tag_q[idx] == tag) &&
                    !(inv_valid && (inv_idx == idx));
  assign hit_word = line_q[idx][word_sel*32 +: 32];

  assign fill_valid = (state_q == st_miss_wait) && rtrn_valid_i &&
                      (rtrn_i.rtype == rtrn_fill_ack);
  assign fill_alloc = fill_valid && !nc && !stale_q;
  // nc returns replicate the word, so any lane works
  assign fill_word  = rtrn_i.payload.data[word_sel*32 +: 32];

  assign fetch_ready_o    = (state_q == st_idle);
  assign fetch_rsp_addr_o = addr_q;
  assign req_paddr_o      = nc ? {addr_q[31:2], 2'b00} : {addr_q[31:offset_width], 4'h0};
  assign req_nc_o         = nc;

  always_comb begin
    state_d           = state_q;
    fetch_rsp_valid_o = 1'b0;
    fetch_rsp_data_o  = rsp_data_q;
    req_valid_o       = 1'b0;
    case (state_q)
      st_idle: begin
        if (fetch_valid_i) begin
          state_d = st_lookup;
        end
      end
      st_lookup: begin
        if (hit) begin
          fetch_rsp_valid_o = 1'b1;
          fetch_rsp_data_o  = hit_word;
          state_d           = fetch_rsp_ready_i ? st_idle : st_respond;
        end else begin
          // request leaves in the lookup cycle to save one cycle per miss
          req_valid_o = 1'b1;
          state_d     = req_ready_i ? st_miss_wait : st_miss_req;
        end
      end
      st_miss_req: begin
        req_valid_o = 1'b1;
        if (req_ready_i) begin
          state_d = st_miss_wait;
        end
      end
      st_miss_wait: begin
        if (fill_valid) begin
          state_d = st_respond;
        end
      end
      st_respond: begin
        fetch_rsp_valid_o = 1'b1;
        if (fetch_rsp_ready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      valid_q <= '0;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // direct mapped, so every invalidation drops exactly one set
      if (inv_valid) begin
        valid_q[inv_idx] <= 1'b0;
      end else if (fill_alloc) begin
        valid_q[idx] <= 1'b1;
      end
      if (fetch_valid_i && fetch_ready_o) begin
        stale_q <= 1'b0;
      end else if (inv_valid && (inv_idx == idx) &&
                   ((state_q == st_miss_req) || (state_q == st_miss_wait))) begin
        stale_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
    if ((state_q == st_lookup) && hit) begin
      rsp_data_q <= hit_word;
    end else if (fill_valid) begin
      rsp_data_q <= fill_word;
    end
    if (fill_alloc) begin
      tag_q[idx]  <= tag;
      line_q[idx] <= rtrn_i.payload.data;
    end
  end

  a_fetch_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i |-> fetch_addr_i[1:0] == 2'b00)
    else $error("fetch address not word aligned");

  a_fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_o |=> !fetch_valid_i || $stable(fetch_addr_i))
    else $error("fetch address changed while waiting");

endmodule

//--- hw/mem_emul.sv
// mem_words must be a power of two; addresses past the memory wrap, contents clear on reset
`timescale 1ns/10ps

module mem_emul #(
  parameter int unsigned mem_words       = 1024,
  parameter int unsigned cached_addr_beg = 2048,
  parameter int unsigned stall_rate      = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              stall_en_i,
  input  logic              wr_valid_i,
  input  logic [31:0]       wr_addr_i,
  input  logic [31:0]       wr_data_i,
  output logic              wr_ready_o,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [31:0]       req_paddr_i,
  input  logic              req_nc_i,
  output logic              rtrn_valid_o,
  output icache_pkg::rtrn_t rtrn_o
);

  import icache_pkg::*;

  localparam int unsigned mem_idx_w = $clog2(mem_words);

  logic [31:0]           mem_q [mem_words];
  logic [15:0]           lfsr_q;
  logic                  mem_ready;
  req_t                  reqq_in;
  req_t                  reqq_head;
  logic                  reqq_valid;
  logic                  reqq_pop;
  rtrn_t                 rtrn_push_data;
  logic                  rtrnq_push;
  logic                  rtrnq_ready;
  logic                  wr_acc;
  logic                  wr_inv;
  logic [mem_idx_w-1:0]  head_idx;
  logic [line_width-1:0] fill_line;

  // contention source, advances every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 16'hace1;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

  assign mem_ready = !stall_en_i || ({1'b0, lfsr_q[7:0]} < 9'(stall_rate));

  // write port needs room for the invalidation it may cause
  assign wr_ready_o = rtrnq_ready;
  assign wr_acc     = wr_valid_i && wr_ready_o;
  assign wr_inv     = wr_acc && (wr_addr_i >= cached_addr_beg);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < mem_words; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_acc) begin
      mem_q[wr_addr_i[2 +: mem_idx_w]] <= wr_data_i;
    end
  end

  assign reqq_in = '{paddr: req_paddr_i, nc: req_nc_i};

  stream_fifo #(
    .depth (2),
    .dtype (req_t)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (reqq_in),
    .valid_o (reqq_valid),
    .ready_i (reqq_pop),
    .data_o  (reqq_head)
  );

  // invalidation owns the return queue in its cycle
  assign reqq_pop   = reqq_valid && rtrnq_ready && mem_ready && !wr_inv;
  assign rtrnq_push = wr_inv || reqq_pop;
  assign head_idx   = reqq_head.paddr[2 +: mem_idx_w];

  always_comb begin
    fill_line = '0;
    for (int k = 0; k < line_words; k++) begin
      if (reqq_head.nc) begin
        fill_line[k*32 +: 32] = mem_q[head_idx];
      end else begin
        fill_line[k*32 +: 32] = mem_q[head_idx + mem_idx_w'(k)];
      end
    end
  end

  always_comb begin
    rtrn_push_data = '0;
    if (wr_inv) begin
      rtrn_push_data.rtype             = rtrn_inv_req;
      rtrn_push_data.payload.inv.idx   = wr_addr_i[offset_width +: index_width];
      rtrn_push_data.payload.inv.all   = 1'b1;
    end else begin
      rtrn_push_data.rtype        = rtrn_fill_ack;
      rtrn_push_data.payload.data = fill_line;
    end
  end

  // the cache takes a return every cycle, so the queue drains whenever non-empty
  stream_fifo #(
    .depth (2),
    .dtype (rtrn_t)
  ) i_rtrn_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (rtrnq_push),
    .ready_o (rtrnq_ready),
    .data_i  (rtrn_push_data),
    .valid_o (rtrn_valid_o),
    .ready_i (1'b1),
    .data_o  (rtrn_o)
  );

  a_req_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reqq_valid |-> reqq_head.paddr[1:0] == 2'b00)
    else $error("refill address not word aligned");

  // the invalidation is the very next return, no fill slips in ahead of it
  a_inv_return: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_inv |=> rtrn_valid_o && (rtrn_o.rtype == rtrn_inv_req) &&
      (rtrn_o.payload.inv.idx == $past(wr_addr_i[offset_width +: index_width])))
    else $error("invalidation did not follow its write");

endmodule

//--- hw/icache_subsys_top.sv
// fetch addresses must be word aligned and held while fetch_valid_i is high
`timescale 1ns/10ps

module icache_subsys_top #(
  parameter int unsigned mem_words       = 1024,
  parameter int unsigned cached_addr_beg = 2048,
  parameter int unsigned stall_rate      = 64
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stall_en_i,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_addr_i,
  output logic        fetch_ready_o,
  output logic        fetch_rsp_valid_o,
  output logic [31:0] fetch_rsp_data_o,
  output logic [31:0] fetch_rsp_addr_o,
  input  logic        fetch_rsp_ready_i,
  input  logic        wr_valid_i,
  input  logic [31:0] wr_addr_i,
  input  logic [31:0] wr_data_i,
  output logic        wr_ready_o
);

  import icache_pkg::*;

  // refill path
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_paddr;
  logic        req_nc;

  // return path, no back-pressure
  logic        rtrn_valid;
  rtrn_t       rtrn_data;

  icache_core #(
    .cached_addr_beg (cached_addr_beg)
  ) i_icache (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_data_o  (fetch_rsp_data_o),
    .fetch_rsp_addr_o  (fetch_rsp_addr_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .req_valid_o       (req_valid),
    .req_ready_i       (req_ready),
    .req_paddr_o       (req_paddr),
    .req_nc_o          (req_nc),
    .rtrn_valid_i      (rtrn_valid),
    .rtrn_i            (rtrn_data)
  );

  mem_emul #(
    .mem_words       (mem_words),
    .cached_addr_beg (cached_addr_beg),
    .stall_rate      (stall_rate)
  ) i_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_en_i   (stall_en_i),
    .wr_valid_i   (wr_valid_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .wr_ready_o   (wr_ready_o),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_paddr_i  (req_paddr),
    .req_nc_i     (req_nc),
    .rtrn_valid_o (rtrn_valid),
    .rtrn_o       (rtrn_data)
  );

endmodule

//--- tests/icache_tb_props.svh
// needs exp_addr, exp_now, exp_old, exp_cnt and err_cnt declared in the including module
`ifndef icache_tb_props_svh
`define icache_tb_props_svh

  // data of an accepted response; the old value counts when a write raced the fetch
  a_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_valid_o && fetch_rsp_ready_i && (exp_cnt != 0) |->
      (fetch_rsp_data_o == exp_now) || (fetch_rsp_data_o == exp_old))
    else begin
      $display("MISMATCH time=%0t signal=fetch_rsp_data_o got=%h expected=%h",
               $time, $sampled(fetch_rsp_data_o), $sampled(exp_now));
      err_cnt++;
    end

  // responses come back in fetch order
  a_rsp_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_valid_o && fetch_rsp_ready_i && (exp_cnt != 0) |->
      fetch_rsp_addr_o == exp_addr)
    else begin
      $display("MISMATCH time=%0t signal=fetch_rsp_addr_o got=%h expected=%h",
               $time, $sampled(fetch_rsp_addr_o), $sampled(exp_addr));
      err_cnt++;
    end

  a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_valid_o |-> exp_cnt != 0)
    else begin
      $display("time=%0t a response appeared with no fetch outstanding", $time);
      err_cnt++;
    end

  // back-pressure holds the response
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_valid_o && !fetch_rsp_ready_i |=>
      fetch_rsp_valid_o && $stable(fetch_rsp_data_o) && $stable(fetch_rsp_addr_o))
    else begin
      $display("time=%0t the response dropped or changed while stalled", $time);
      err_cnt++;
    end

  a_busy_while_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_valid_o |-> !fetch_ready_o)
    else begin
      $display("time=%0t a new fetch was offered while a response was pending", $time);
      err_cnt++;
    end

  // idle outputs right after reset release
  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !fetch_rsp_valid_o && fetch_ready_o && wr_ready_o)
    else begin
      $display("time=%0t outputs not idle after reset", $time);
      err_cnt++;
    end

`endif

//--- tests/tb_icache_subsys.sv
// uses the default subsystem parameters; all test addresses stay inside the 4 KiB memory
`timescale 1ns/10ps

module tb_icache_subsys;

  localparam int unsigned mem_words       = 1024;
  localparam int unsigned cached_addr_beg = 2048;
  localparam int unsigned stall_rate      = 64;
  localparam int unsigned mem_idx_w       = $clog2(mem_words);
  // roughly twice the summed length of all tests
  localparam int unsigned max_cycles      = 4000;

  logic        clk_i;
  logic        rst_ni;
  logic        stall_en_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_addr_i;
  logic        fetch_ready_o;
  logic        fetch_rsp_valid_o;
  logic [31:0] fetch_rsp_data_o;
  logic [31:0] fetch_rsp_addr_o;
  logic        fetch_rsp_ready_i;
  logic        wr_valid_i;
  logic [31:0] wr_addr_i;
  logic [31:0] wr_data_i;
  logic        wr_ready_o;

  // reference memory and outstanding fetches
  logic [31:0] ref_mem [mem_words];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_old_q [$];
  logic [31:0] exp_addr;
  logic [31:0] exp_now;
  logic [31:0] exp_old;
  int          exp_cnt;
  logic        bp_en;
  int          err_cnt;
  int          cycle_cnt;
  int          tests_run;
  int          tests_failed;

  icache_subsys_top #(
    .mem_words       (mem_words),
    .cached_addr_beg (cached_addr_beg),
    .stall_rate      (stall_rate)
  ) UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .stall_en_i        (stall_en_i),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_data_o  (fetch_rsp_data_o),
    .fetch_rsp_addr_o  (fetch_rsp_addr_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .wr_valid_i        (wr_valid_i),
    .wr_addr_i         (wr_addr_i),
    .wr_data_i         (wr_data_i),
    .wr_ready_o        (wr_ready_o)
  );

  `include "icache_tb_props.svh"

  always #20 clk_i = ~clk_i;

  // model update; pops, then writes, then new fetches
  always @(posedge clk_i) begin
    if (fetch_rsp_valid_o && fetch_rsp_ready_i && (exp_addr_q.size() != 0)) begin
      void'(exp_addr_q.pop_front());
      void'(exp_old_q.pop_front());
    end
    if (wr_valid_i && wr_ready_o) begin
      ref_mem[wr_addr_i[2 +: mem_idx_w]] = wr_data_i;
    end
    if (fetch_valid_i && fetch_ready_o) begin
      exp_addr_q.push_back(fetch_addr_i);
      exp_old_q.push_back(ref_mem[fetch_addr_i[2 +: mem_idx_w]]);
    end
    exp_cnt = exp_addr_q.size();
    if (exp_cnt != 0) begin
      exp_addr = exp_addr_q[0];
      exp_old  = exp_old_q[0];
      exp_now  = ref_mem[exp_addr[2 +: mem_idx_w]];
    end
  end

  // random back-pressure on the response
  always @(posedge clk_i) begin
    if (bp_en) begin
      fetch_rsp_ready_i <= ($urandom % 3) != 0;
    end else begin
      fetch_rsp_ready_i <= 1'b1;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
    $display("tests failed");
    $finish;
  end

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    wr_valid_i <= 1'b1;
    wr_addr_i  <= addr;
    wr_data_i  <= data;
    do begin
      @(posedge clk_i);
    end while (!wr_ready_o);
    wr_valid_i <= 1'b0;
  endtask

  // returns once the response has been taken
  task automatic fetch_word(input logic [31:0] addr);
    fetch_valid_i <= 1'b1;
    fetch_addr_i  <= addr;
    do begin
      @(posedge clk_i);
    end while (!fetch_ready_o);
    fetch_valid_i <= 1'b0;
    do begin
      @(posedge clk_i);
    end while (!(fetch_rsp_valid_o && fetch_rsp_ready_i));
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_start);
    end
  endtask

  initial begin
    logic [31:0] addr;
    int          err_start;
    void'($urandom(32'h1f4d00a5));
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    stall_en_i        = 1'b0;
    fetch_valid_i     = 1'b0;
    fetch_addr_i      = '0;
    fetch_rsp_ready_i = 1'b1;
    wr_valid_i        = 1'b0;
    wr_addr_i         = '0;
    wr_data_i         = '0;
    bp_en             = 1'b0;
    err_cnt           = 0;
    tests_run         = 0;
    tests_failed      = 0;
    exp_cnt           = 0;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = '0;
    end

    err_start = err_cnt;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    end_test("reset state", err_start);

    // eight lines, sets 0 to 7, first pass misses and second pass hits
    err_start = err_cnt;
    for (int i = 0; i < 32; i++) begin
      write_word(cached_addr_beg + 4 * i, $urandom);
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 32; i++) begin
        fetch_word(cached_addr_beg + 4 * i);
      end
    end
    end_test("cacheable fill and hit", err_start);

    err_start = err_cnt;
    for (int i = 0; i < 8; i++) begin
      addr = 256 + 16 * i;
      write_word(addr, $urandom);
      fetch_word(addr);
      fetch_word(addr);
      write_word(addr, $urandom);
      fetch_word(addr);
    end
    end_test("non-cacheable fetch", err_start);

    err_start = err_cnt;
    for (int i = 0; i < 4; i++) begin
      addr = cached_addr_beg + 16 * i + 4;
      fetch_word(addr);
      write_word(addr, $urandom);
      fetch_word(addr);
    end
    // write lands at a different point of the refill each round
    for (int i = 0; i < 4; i++) begin
      addr = 3072 + 16 * i;
      fork
        fetch_word(addr);
        begin
          repeat (i + 1) @(posedge clk_i);
          write_word(addr + 4 * ((i + 1) % 4), $urandom);
        end
      join
      fetch_word(addr + 4 * ((i + 1) % 4));
      fetch_word(addr);
    end
    end_test("coherence with writes", err_start);

    err_start = err_cnt;
    stall_en_i <= 1'b1;
    bp_en      <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      fetch_word(($urandom % mem_words) * 4);
    end
    stall_en_i <= 1'b0;
    bp_en      <= 1'b0;
    repeat (4) @(posedge clk_i);
    end_test("contention and back-pressure", err_start);

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if ((tests_failed == 0) && (err_cnt == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+tests
hw/icache_pkg.sv
hw/stream_fifo.sv
hw/icache_core.sv
hw/mem_emul.sv
hw/icache_subsys_top.sv
tests/tb_icache_subsys.sv
